/* logic/mcu_pkg.sv */
/*
  Memory map and register layout of the bus. Word accesses only, the two
  low address bits are ignored everywhere.
*/
package mcu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // top 4 address bits
  localparam logic [3:0] REGION_RAM    = 4'h0;
  localparam logic [3:0] REGION_PERIPH = 4'h1;

  localparam int RAM_WORDS = 256;
  localparam int RAM_IDX_W = 8;

  // peripheral block, address bits 11..8
  localparam logic [3:0] BLOCK_GPIO = 4'd0;
  localparam logic [3:0] BLOCK_DMA  = 4'd1;

  localparam int NUM_GPIO = 32;

  localparam logic [5:0] GPIO_OUT        = 6'd0;
  localparam logic [5:0] GPIO_OE         = 6'd1;
  localparam logic [5:0] GPIO_IN         = 6'd2;
  localparam logic [5:0] GPIO_IRQ_EN     = 6'd3;
  localparam logic [5:0] GPIO_IRQ_STATUS = 6'd4;

  localparam logic [5:0] DMA_SRC  = 6'd0;
  localparam logic [5:0] DMA_DST  = 6'd1;
  localparam logic [5:0] DMA_LEN  = 6'd2;
  localparam logic [5:0] DMA_CTRL = 6'd3;

  // start is written and busy is read on the same bit
  localparam int DMA_START = 0;
  localparam int DMA_BUSY  = 0;
  localparam int DMA_DONE  = 1;
  localparam int DMA_ERR   = 2;

  localparam int NUM_INTR  = 2;
  localparam int INTR_GPIO = 0;
  localparam int INTR_DMA  = 1;

  typedef union packed {
    struct packed {
      logic [3:0]                          region;
      logic [ADDR_W-RAM_IDX_W-7:0]         unused;
      logic [RAM_IDX_W-1:0]                idx;
      logic [1:0]                          byte_off;
    } ram;
    struct packed {
      logic [3:0]  region;
      logic [15:0] unused;
      logic [3:0]  block;
      logic [5:0]  reg_off;
      logic [1:0]  byte_off;
    } periph;
  } bus_addr_u;

endpackage

/* logic/bus_arbiter.sv */
/*
  Round-robin arbiter for two Wishbone classic masters (m0 host, m1 DMA).
  The grant stays with a master for as long as it holds cyc.
*/
`timescale 1ns/1ps

module bus_arbiter
  import mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              m0_cyc_i,
  input  logic              m0_stb_i,
  input  logic              m0_we_i,
  input  logic [ADDR_W-1:0] m0_adr_i,
  input  logic [DATA_W-1:0] m0_dat_i,
  output logic [DATA_W-1:0] m0_dat_o,
  output logic              m0_ack_o,
  output logic              m0_err_o,
  input  logic              m1_cyc_i,
  input  logic              m1_stb_i,
  input  logic              m1_we_i,
  input  logic [ADDR_W-1:0] m1_adr_i,
  input  logic [DATA_W-1:0] m1_dat_i,
  output logic [DATA_W-1:0] m1_dat_o,
  output logic              m1_ack_o,
  output logic              m1_err_o,
  output logic              bus_cyc_o,
  output logic              bus_stb_o,
  output logic              bus_we_o,
  output logic [ADDR_W-1:0] bus_adr_o,
  output logic [DATA_W-1:0] bus_dat_o,
  input  logic [DATA_W-1:0] bus_dat_i,
  input  logic              bus_ack_i,
  input  logic              bus_err_i
);

  logic locked_q;
  // last master that held the bus
  logic owner_q;
  logic owner_cyc;
  logic sel;

  assign owner_cyc = owner_q ? m1_cyc_i : m0_cyc_i;

  always_comb begin
    if (locked_q && owner_cyc) begin
      sel = owner_q;
    end else if (m0_cyc_i && m1_cyc_i) begin
      sel = ~owner_q;
    end else begin
      sel = m1_cyc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      locked_q <= 1'b0;
      // host first after reset
      owner_q  <= 1'b1;
    end else begin
      locked_q <= bus_cyc_o;
      if (bus_cyc_o) begin
        owner_q <= sel;
      end
    end
  end

  assign bus_cyc_o = sel ? m1_cyc_i : m0_cyc_i;
  assign bus_stb_o = sel ? m1_stb_i : m0_stb_i;
  assign bus_we_o  = sel ? m1_we_i  : m0_we_i;
  assign bus_adr_o = sel ? m1_adr_i : m0_adr_i;
  assign bus_dat_o = sel ? m1_dat_i : m0_dat_i;

  assign m0_dat_o = sel ? '0 : bus_dat_i;
  assign m0_ack_o = ~sel & bus_ack_i;
  assign m0_err_o = ~sel & bus_err_i;
  assign m1_dat_o = sel ? bus_dat_i : '0;
  assign m1_ack_o = sel & bus_ack_i;
  assign m1_err_o = sel & bus_err_i;

endmodule

/* logic/bus_decoder.sv */
/*
  Address decoder for the shared bus. Unmapped regions and peripheral
  blocks answer with err one cycle after stb, never with ack.
*/
`timescale 1ns/1ps

module bus_decoder
  import mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              bus_cyc_i,
  input  logic              bus_stb_i,
  input  logic [ADDR_W-1:0] bus_adr_i,
  output logic [DATA_W-1:0] bus_dat_o,
  output logic              bus_ack_o,
  output logic              bus_err_o,
  output logic              ram_stb_o,
  output logic              gpio_stb_o,
  output logic              dma_stb_o,
  input  logic [DATA_W-1:0] ram_dat_i,
  input  logic              ram_ack_i,
  input  logic [DATA_W-1:0] gpio_dat_i,
  input  logic              gpio_ack_i,
  input  logic [DATA_W-1:0] dma_dat_i,
  input  logic              dma_ack_i
);

  bus_addr_u addr;
  logic      req;
  logic      ram_sel;
  logic      gpio_sel;
  logic      dma_sel;
  logic      unmapped;
  logic      err_q;

  assign addr = bus_adr_i;
  assign req  = bus_cyc_i & bus_stb_i;

  assign ram_sel  = (addr.ram.region == REGION_RAM);
  assign gpio_sel = (addr.periph.region == REGION_PERIPH) && (addr.periph.block == BLOCK_GPIO);
  assign dma_sel  = (addr.periph.region == REGION_PERIPH) && (addr.periph.block == BLOCK_DMA);
  assign unmapped = req & ~(ram_sel | gpio_sel | dma_sel);

  assign ram_stb_o  = req & ram_sel;
  assign gpio_stb_o = req & gpio_sel;
  assign dma_stb_o  = req & dma_sel;

  // same one-cycle pulse as the slaves' ack
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= unmapped & ~err_q;
    end
  end

  // address is held by the master until the response
  always_comb begin
    if (ram_sel) begin
      bus_dat_o = ram_dat_i;
    end else if (gpio_sel) begin
      bus_dat_o = gpio_dat_i;
    end else if (dma_sel) begin
      bus_dat_o = dma_dat_i;
    end else begin
      bus_dat_o = '0;
    end
  end

  assign bus_ack_o = ram_ack_i | gpio_ack_i | dma_ack_i;
  assign bus_err_o = err_q;

endmodule

/* logic/ram_bank.sv */
/*
  256-word SRAM, whole words only. The bank repeats every 1 KiB inside
  the RAM region. stb_i must be low in the first clock after power-up.
*/
`timescale 1ns/1ps

module ram_bank
  import mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] adr_i,
  input  logic [DATA_W-1:0] dat_i,
  output logic [DATA_W-1:0] dat_o,
  output logic              ack_o
);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  bus_addr_u         addr;
  logic              ack_q;
  logic [DATA_W-1:0] rdata_q;

  assign addr = adr_i;

  always_ff @(posedge clk_i) begin
    // one ack per request, then a quiet cycle
    ack_q <= stb_i & ~ack_q;
  end

  always_ff @(posedge clk_i) begin
    if (stb_i && we_i && !ack_q) begin
      mem[addr.ram.idx] <= dat_i;
    end
    if (stb_i) begin
      rdata_q <= mem[addr.ram.idx];
    end
  end

  assign dat_o = rdata_q;
  assign ack_o = ack_q;

endmodule

/* logic/dma_engine.sv */
/*
  Word-copy DMA. Copies LEN words from SRC to DST in ascending order and
  frees the bus between words. A bus error ends the copy with DONE and ERR.
*/
`timescale 1ns/1ps

module dma_engine
  import mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] adr_i,
  input  logic [DATA_W-1:0] dat_i,
  output logic [DATA_W-1:0] dat_o,
  output logic              ack_o,
  output logic              m_cyc_o,
  output logic              m_stb_o,
  output logic              m_we_o,
  output logic [ADDR_W-1:0] m_adr_o,
  output logic [DATA_W-1:0] m_dat_o,
  input  logic [DATA_W-1:0] m_dat_i,
  input  logic              m_ack_i,
  input  logic              m_err_i,
  output logic              irq_o
);

  bus_addr_u         addr;
  logic              ack_q;
  logic              wr;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] ctrl_rd;
  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [DATA_W-1:0] len_q;
  logic              busy_q;
  logic              done_q;
  logic              err_q;
  logic              wr_phase_q;
  logic              gap_q;
  logic [DATA_W-1:0] buf_q;

  assign addr = adr_i;
  assign wr   = stb_i & we_i & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q      <= 1'b0;
      src_q      <= '0;
      dst_q      <= '0;
      len_q      <= '0;
      busy_q     <= 1'b0;
      done_q     <= 1'b0;
      err_q      <= 1'b0;
      wr_phase_q <= 1'b0;
      gap_q      <= 1'b0;
    end else begin
      ack_q <= stb_i & ~ack_q;
      gap_q <= 1'b0;
      if (busy_q && !gap_q) begin
        if (m_err_i) begin
          busy_q     <= 1'b0;
          done_q     <= 1'b1;
          err_q      <= 1'b1;
          wr_phase_q <= 1'b0;
        end else if (m_ack_i) begin
          wr_phase_q <= ~wr_phase_q;
          if (wr_phase_q) begin
            src_q <= src_q + 4;
            dst_q <= dst_q + 4;
            len_q <= len_q - 1;
            if (len_q == 1) begin
              busy_q <= 1'b0;
              done_q <= 1'b1;
            end else begin
              // drop cyc for a cycle so the host can get in
              gap_q <= 1'b1;
            end
          end
        end
      end
      if (wr && !busy_q) begin
        case (addr.periph.reg_off)
          DMA_SRC: src_q <= dat_i;
          DMA_DST: dst_q <= dat_i;
          DMA_LEN: len_q <= dat_i;
          default: ;
        endcase
      end
      if (wr && addr.periph.reg_off == DMA_CTRL) begin
        if (dat_i[DMA_DONE]) begin
          done_q <= 1'b0;
          err_q  <= 1'b0;
        end
        if (dat_i[DMA_START] && !busy_q) begin
          done_q <= (len_q == 0);
          err_q  <= 1'b0;
          busy_q <= (len_q != 0);
        end
      end
    end
  end

  // read data of the current word
  always_ff @(posedge clk_i) begin
    if (busy_q && !wr_phase_q && m_ack_i) begin
      buf_q <= m_dat_i;
    end
  end

  always_comb begin
    ctrl_rd           = '0;
    ctrl_rd[DMA_BUSY] = busy_q;
    ctrl_rd[DMA_DONE] = done_q;
    ctrl_rd[DMA_ERR]  = err_q;
  end

  always_ff @(posedge clk_i) begin
    if (stb_i) begin
      case (addr.periph.reg_off)
        DMA_SRC:  rdata_q <= src_q;
        DMA_DST:  rdata_q <= dst_q;
        DMA_LEN:  rdata_q <= len_q;
        DMA_CTRL: rdata_q <= ctrl_rd;
        default:  rdata_q <= '0;
      endcase
    end
  end

  assign dat_o   = rdata_q;
  assign ack_o   = ack_q;
  assign m_cyc_o = busy_q & ~gap_q;
  assign m_stb_o = busy_q & ~gap_q;
  assign m_we_o  = wr_phase_q;
  assign m_adr_o = wr_phase_q ? dst_q : src_q;
  assign m_dat_o = buf_q;
  assign irq_o   = done_q;

endmodule

/* logic/gpio_block.sv */
/*
  32-pin GPIO. Inputs pass a two-flop synchronizer, so GPIO_IN lags the
  pins by two clocks. Status bits are set on rising edges of enabled pins.
*/
`timescale 1ns/1ps

module gpio_block
  import mcu_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [ADDR_W-1:0]   adr_i,
  input  logic [DATA_W-1:0]   dat_i,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [DATA_W-1:0]   dat_o,
  output logic                ack_o,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic                irq_o
);

  bus_addr_u           addr;
  logic                ack_q;
  logic                wr;
  logic [DATA_W-1:0]   rdata_q;
  logic [NUM_GPIO-1:0] out_q;
  logic [NUM_GPIO-1:0] oe_q;
  logic [NUM_GPIO-1:0] irq_en_q;
  logic [NUM_GPIO-1:0] status_q;
  logic [NUM_GPIO-1:0] sync1_q;
  logic [NUM_GPIO-1:0] sync2_q;
  logic [NUM_GPIO-1:0] prev_q;
  logic [NUM_GPIO-1:0] clr;

  assign addr = adr_i;
  assign wr   = stb_i & we_i & ~ack_q;
  assign clr  = (wr && addr.periph.reg_off == GPIO_IRQ_STATUS) ? dat_i : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      out_q    <= '0;
      oe_q     <= '0;
      irq_en_q <= '0;
      status_q <= '0;
      sync1_q  <= '0;
      sync2_q  <= '0;
      prev_q   <= '0;
    end else begin
      ack_q   <= stb_i & ~ack_q;
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      // a new edge wins over a clear in the same cycle
      status_q <= (status_q & ~clr) | (sync2_q & ~prev_q & irq_en_q);
      if (wr) begin
        case (addr.periph.reg_off)
          GPIO_OUT:    out_q    <= dat_i;
          GPIO_OE:     oe_q     <= dat_i;
          GPIO_IRQ_EN: irq_en_q <= dat_i;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (stb_i) begin
      case (addr.periph.reg_off)
        GPIO_OUT:        rdata_q <= out_q;
        GPIO_OE:         rdata_q <= oe_q;
        GPIO_IN:         rdata_q <= sync2_q;
        GPIO_IRQ_EN:     rdata_q <= irq_en_q;
        GPIO_IRQ_STATUS: rdata_q <= status_q;
        default:         rdata_q <= '0;
      endcase
    end
  end

  assign dat_o     = rdata_q;
  assign ack_o     = ack_q;
  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign irq_o     = |status_q;

endmodule

/* logic/mini_mcu.sv */
/*
  Two-master system bus with RAM, GPIO and DMA. The host port is a
  Wishbone classic master and must hold its request until ack or err.
*/
`timescale 1ns/1ps

module mini_mcu
  import mcu_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                host_cyc_i,
  input  logic                host_stb_i,
  input  logic                host_we_i,
  input  logic [ADDR_W-1:0]   host_adr_i,
  input  logic [DATA_W-1:0]   host_dat_i,
  output logic [DATA_W-1:0]   host_dat_o,
  output logic                host_ack_o,
  output logic                host_err_o,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic [NUM_INTR-1:0] intr_o
);

  // dma master side
  logic              dma_cyc, dma_stb, dma_we, dma_ack, dma_err;
  logic [ADDR_W-1:0] dma_adr;
  logic [DATA_W-1:0] dma_wdat, dma_rdat;

  // shared bus
  logic              bus_cyc, bus_stb, bus_we, bus_ack, bus_err;
  logic [ADDR_W-1:0] bus_adr;
  logic [DATA_W-1:0] bus_wdat, bus_rdat;

  logic              ram_stb, gpio_stb, dma_sstb;
  logic              ram_ack, gpio_ack, dma_sack;
  logic [DATA_W-1:0] ram_dat, gpio_dat, dma_sdat;
  logic              gpio_irq, dma_irq;

  bus_arbiter u_arbiter (
    .clk_i,
    .rst_i,
    .m0_cyc_i (host_cyc_i),
    .m0_stb_i (host_stb_i),
    .m0_we_i  (host_we_i),
    .m0_adr_i (host_adr_i),
    .m0_dat_i (host_dat_i),
    .m0_dat_o (host_dat_o),
    .m0_ack_o (host_ack_o),
    .m0_err_o (host_err_o),
    .m1_cyc_i (dma_cyc),
    .m1_stb_i (dma_stb),
    .m1_we_i  (dma_we),
    .m1_adr_i (dma_adr),
    .m1_dat_i (dma_wdat),
    .m1_dat_o (dma_rdat),
    .m1_ack_o (dma_ack),
    .m1_err_o (dma_err),
    .bus_cyc_o(bus_cyc),
    .bus_stb_o(bus_stb),
    .bus_we_o (bus_we),
    .bus_adr_o(bus_adr),
    .bus_dat_o(bus_wdat),
    .bus_dat_i(bus_rdat),
    .bus_ack_i(bus_ack),
    .bus_err_i(bus_err)
  );

  bus_decoder u_decoder (
    .clk_i,
    .rst_i,
    .bus_cyc_i (bus_cyc),
    .bus_stb_i (bus_stb),
    .bus_adr_i (bus_adr),
    .bus_dat_o (bus_rdat),
    .bus_ack_o (bus_ack),
    .bus_err_o (bus_err),
    .ram_stb_o (ram_stb),
    .gpio_stb_o(gpio_stb),
    .dma_stb_o (dma_sstb),
    .ram_dat_i (ram_dat),
    .ram_ack_i (ram_ack),
    .gpio_dat_i(gpio_dat),
    .gpio_ack_i(gpio_ack),
    .dma_dat_i (dma_sdat),
    .dma_ack_i (dma_sack)
  );

  ram_bank u_ram (
    .clk_i,
    .stb_i(ram_stb),
    .we_i (bus_we),
    .adr_i(bus_adr),
    .dat_i(bus_wdat),
    .dat_o(ram_dat),
    .ack_o(ram_ack)
  );

  gpio_block u_gpio (
    .clk_i,
    .rst_i,
    .stb_i    (gpio_stb),
    .we_i     (bus_we),
    .adr_i    (bus_adr),
    .dat_i    (bus_wdat),
    .gpio_i,
    .dat_o    (gpio_dat),
    .ack_o    (gpio_ack),
    .gpio_o,
    .gpio_oe_o,
    .irq_o    (gpio_irq)
  );

  dma_engine u_dma (
    .clk_i,
    .rst_i,
    .stb_i  (dma_sstb),
    .we_i   (bus_we),
    .adr_i  (bus_adr),
    .dat_i  (bus_wdat),
    .dat_o  (dma_sdat),
    .ack_o  (dma_sack),
    .m_cyc_o(dma_cyc),
    .m_stb_o(dma_stb),
    .m_we_o (dma_we),
    .m_adr_o(dma_adr),
    .m_dat_o(dma_wdat),
    .m_dat_i(dma_rdat),
    .m_ack_i(dma_ack),
    .m_err_i(dma_err),
    .irq_o  (dma_irq)
  );

  assign intr_o[INTR_GPIO] = gpio_irq;
  assign intr_o[INTR_DMA]  = dma_irq;

endmodule

/* tb/mcu_checker.sv */
/*
  Reference model of RAM, GPIO and DMA as seen from the host port. Pins and
  intr_o are compared only while check_outputs_i is high.
*/
`timescale 1ns/1ps

module mcu_checker
  import mcu_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                host_cyc_i,
  input  logic                host_we_i,
  input  logic [ADDR_W-1:0]   host_adr_i,
  input  logic [DATA_W-1:0]   host_wdat_i,
  input  logic [DATA_W-1:0]   host_rdat_i,
  input  logic                host_ack_i,
  input  logic                host_err_i,
  input  logic [NUM_GPIO-1:0] pins_in_i,
  input  logic [NUM_GPIO-1:0] pins_out_i,
  input  logic [NUM_GPIO-1:0] pins_oe_i,
  input  logic [NUM_INTR-1:0] intr_i,
  input  logic [3:0]          test_idx_i,
  input  logic                check_outputs_i,
  input  logic                host_timeout_i,
  input  logic                dma_timeout_i,
  input  logic                all_done_i,
  output logic                finished_o,
  output logic                failed_o
);

  logic [DATA_W-1:0]   ram_m [RAM_WORDS];
  logic [NUM_GPIO-1:0] out_m, oe_m, en_m, status_m, pin_prev;
  logic [ADDR_W-1:0]   src_m, dst_m;
  logic [DATA_W-1:0]   len_m;
  logic                done_m, err_m;
  logic [3:0]          cur_test;
  int checks_t, errors_t, total_checks, total_errors, tests_passed, tests_failed;

  function automatic string name_of(input logic [3:0] idx);
    case (idx)
      4'd1:    return "ram_write_read";
      4'd2:    return "unmapped_access";
      4'd3:    return "gpio_out_in";
      4'd4:    return "gpio_edge_irq";
      4'd5:    return "dma_copy";
      4'd6:    return "dma_error";
      default: return "idle";
    endcase
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks_t++;
    if (exp !== act) begin
      errors_t++;
      $display("Error test %s: %s expected %h actual %h", name_of(cur_test), what, exp, act);
    end
  endtask

  task automatic fail_plain(input string msg);
    checks_t++;
    errors_t++;
    $display("test %s: %s", name_of(cur_test), msg);
  endtask

  task automatic close_test();
    if (cur_test != 0) begin
      if (errors_t == 0) begin
        tests_passed++;
        $display("test %s: passed, %0d checks", name_of(cur_test), checks_t);
      end else begin
        tests_failed++;
        $display("test %s: failed, %0d of %0d checks wrong", name_of(cur_test), errors_t,
                 checks_t);
      end
    end
    total_checks += checks_t;
    total_errors += errors_t;
    checks_t = 0;
    errors_t = 0;
  endtask

  // words are copied one by one in ascending order, so overlap behaves as on the bus
  task automatic run_copy();
    bus_addr_u sa;
    bus_addr_u da;
    for (int i = 0; i < int'(len_m); i++) begin
      sa = src_m + 32'(4 * i);
      da = dst_m + 32'(4 * i);
      if (sa.ram.region != REGION_RAM) begin
        err_m = 1'b1;
        break;
      end
      ram_m[da.ram.idx] = ram_m[sa.ram.idx];
    end
  endtask

  task automatic apply_write(input bus_addr_u a);
    if (a.ram.region == REGION_RAM) begin
      ram_m[a.ram.idx] = host_wdat_i;
    end else if (a.periph.block == BLOCK_GPIO) begin
      case (a.periph.reg_off)
        GPIO_OUT:        out_m = host_wdat_i;
        GPIO_OE:         oe_m = host_wdat_i;
        GPIO_IRQ_EN:     en_m = host_wdat_i;
        GPIO_IRQ_STATUS: status_m = status_m & ~host_wdat_i;
        default: ;
      endcase
    end else begin
      case (a.periph.reg_off)
        DMA_SRC: src_m = host_wdat_i;
        DMA_DST: dst_m = host_wdat_i;
        DMA_LEN: len_m = host_wdat_i;
        DMA_CTRL: begin
          if (host_wdat_i[DMA_DONE]) begin
            done_m = 1'b0;
            err_m  = 1'b0;
          end
          if (host_wdat_i[DMA_START]) begin
            done_m = 1'b1;
            err_m  = 1'b0;
            run_copy();
          end
        end
        default: ;
      endcase
    end
  endtask

  task automatic compare_read(input bus_addr_u a);
    logic [DATA_W-1:0] ctrl;
    ctrl           = '0;
    ctrl[DMA_DONE] = done_m;
    ctrl[DMA_ERR]  = err_m;
    if (a.ram.region == REGION_RAM) begin
      compare("ram word", ram_m[a.ram.idx], host_rdat_i);
    end else if (a.periph.block == BLOCK_GPIO) begin
      if (a.periph.reg_off == GPIO_IN) begin
        compare("gpio_in", pins_in_i, host_rdat_i);
      end else if (a.periph.reg_off == GPIO_IRQ_STATUS) begin
        compare("irq_status", status_m, host_rdat_i);
      end
    end else if (a.periph.reg_off == DMA_CTRL) begin
      compare("dma_ctrl", ctrl, host_rdat_i);
    end
  endtask

  task automatic observe_response();
    bus_addr_u a;
    logic      mapped;
    a      = host_adr_i;
    mapped = (a.ram.region == REGION_RAM) ||
             ((a.periph.region == REGION_PERIPH) &&
              ((a.periph.block == BLOCK_GPIO) || (a.periph.block == BLOCK_DMA)));
    if (host_err_i) begin
      if (mapped) begin
        fail_plain("err returned for a mapped address");
      end else begin
        checks_t++;
      end
    end else if (!mapped) begin
      fail_plain("ack returned for an unmapped address");
    end else if (host_we_i) begin
      apply_write(a);
    end else begin
      compare_read(a);
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      out_m      = '0;
      oe_m       = '0;
      en_m       = '0;
      status_m   = '0;
      pin_prev   = pins_in_i;
      src_m      = '0;
      dst_m      = '0;
      len_m      = '0;
      done_m     = 1'b0;
      err_m      = 1'b0;
      cur_test   = '0;
      finished_o = 1'b0;
      failed_o   = 1'b0;
    end else if (!finished_o) begin
      if (test_idx_i != cur_test) begin
        close_test();
        cur_test = test_idx_i;
      end
      status_m = status_m | (pins_in_i & ~pin_prev & en_m);
      pin_prev = pins_in_i;
      if (host_cyc_i && (host_ack_i || host_err_i)) begin
        observe_response();
      end
      if (check_outputs_i) begin
        compare("gpio_o", out_m, pins_out_i);
        compare("gpio_oe_o", oe_m, pins_oe_i);
        compare("intr_o", {30'b0, done_m, |status_m}, {30'b0, intr_i});
      end
      if (host_timeout_i) begin
        fail_plain("host access got neither ack nor err in time");
      end
      if (dma_timeout_i) begin
        fail_plain("DMA copy did not raise its done interrupt in time");
      end
      if (all_done_i) begin
        close_test();
        $display("%0d tests passed, %0d failed, %0d checks, %0d errors", tests_passed,
                 tests_failed, total_checks, total_errors);
        failed_o   = (total_errors != 0) || (tests_passed == 0);
        finished_o = 1'b1;
      end
    end
  end

endmodule

/* tb/tb_mini_mcu.sv */
/*
  Host port and GPIO pins are driven from a fixed random seed. All
  comparing happens in mcu_checker.
*/
`timescale 1ns/1ps

module tb_mini_mcu
  import mcu_pkg::*;
();

  localparam int CLK_PERIOD     = 40;
  localparam int RAM_READS      = 64;
  localparam int UNMAPPED_TRIES = 16;
  localparam int GPIO_ROUNDS    = 8;
  localparam int DMA_MAX_LEN    = 16;
  localparam int INTERLEAVE_MAX = 24;
  localparam int HOST_WAIT_MAX  = 20;
  // cycles allowed per host access and per copied DMA word
  localparam int ACCESS_BOUND   = 12;
  localparam int WORD_BOUND     = 10;
  localparam int PLANNED_ACCESSES = RAM_WORDS + RAM_READS + 2 * UNMAPPED_TRIES
                                  + 4 * GPIO_ROUNDS + 8
                                  + 2 * (7 + DMA_MAX_LEN) + INTERLEAVE_MAX;
  localparam int WATCHDOG_NS = (PLANNED_ACCESSES * ACCESS_BOUND
                               + 2 * DMA_MAX_LEN * WORD_BOUND + 200) * CLK_PERIOD;

  logic                clk;
  logic                rst;
  logic                host_cyc, host_stb, host_we, host_ack, host_err;
  logic [ADDR_W-1:0]   host_adr;
  logic [DATA_W-1:0]   host_wdat, host_rdat;
  logic [NUM_GPIO-1:0] pins_in, pins_out, pins_oe;
  logic [NUM_INTR-1:0] intr;
  logic [3:0]          test_idx;
  logic                check_outputs, host_timeout, dma_timeout, all_done;
  logic                finished, failed;
  integer              seed;
  logic [31:0]         r;
  logic [ADDR_W-1:0]   adr;

  mini_mcu dut (
    .clk_i     (clk),
    .rst_i     (rst),
    .host_cyc_i(host_cyc),
    .host_stb_i(host_stb),
    .host_we_i (host_we),
    .host_adr_i(host_adr),
    .host_dat_i(host_wdat),
    .host_dat_o(host_rdat),
    .host_ack_o(host_ack),
    .host_err_o(host_err),
    .gpio_i    (pins_in),
    .gpio_o    (pins_out),
    .gpio_oe_o (pins_oe),
    .intr_o    (intr)
  );

  mcu_checker chk (
    .clk_i(clk), .rst_i(rst),
    .host_cyc_i(host_cyc), .host_we_i(host_we), .host_adr_i(host_adr),
    .host_wdat_i(host_wdat), .host_rdat_i(host_rdat),
    .host_ack_i(host_ack), .host_err_i(host_err),
    .pins_in_i(pins_in), .pins_out_i(pins_out), .pins_oe_i(pins_oe), .intr_i(intr),
    .test_idx_i(test_idx), .check_outputs_i(check_outputs),
    .host_timeout_i(host_timeout), .dma_timeout_i(dma_timeout), .all_done_i(all_done),
    .finished_o(finished), .failed_o(failed)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the test sequence finished");
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic logic [ADDR_W-1:0] ram_addr(input logic [RAM_IDX_W-1:0] idx);
    return {REGION_RAM, 18'h0, idx, 2'b00};
  endfunction

  function automatic logic [ADDR_W-1:0] periph_addr(input logic [3:0] blk,
                                                    input logic [5:0] off);
    return {REGION_PERIPH, 16'h0, blk, off, 2'b00};
  endfunction

  task automatic host_access(input logic we, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] wdat);
    int waited;
    waited = 0;
    @(posedge clk);
    host_cyc  <= 1'b1;
    host_stb  <= 1'b1;
    host_we   <= we;
    host_adr  <= a;
    host_wdat <= wdat;
    @(posedge clk);
    while (!host_ack && !host_err && waited < HOST_WAIT_MAX) begin
      @(posedge clk);
      waited++;
    end
    host_cyc <= 1'b0;
    host_stb <= 1'b0;
    host_we  <= 1'b0;
    if (waited >= HOST_WAIT_MAX) begin
      @(posedge clk);
      host_timeout <= 1'b1;
      @(posedge clk);
      host_timeout <= 1'b0;
    end
  endtask

  task automatic check_pins();
    @(posedge clk);
    check_outputs <= 1'b1;
    @(posedge clk);
    check_outputs <= 1'b0;
  endtask

  task automatic run_dma(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                         input int len, input bit interleave);
    logic [31:0] rv;
    int          n;
    int          waited;
    n      = 0;
    waited = 0;
    host_access(1'b1, periph_addr(BLOCK_DMA, DMA_SRC), src);
    host_access(1'b1, periph_addr(BLOCK_DMA, DMA_DST), dst);
    host_access(1'b1, periph_addr(BLOCK_DMA, DMA_LEN), 32'(len));
    host_access(1'b1, periph_addr(BLOCK_DMA, DMA_CTRL), 32'(1 << DMA_START));
    while (interleave && !intr[INTR_DMA] && n < INTERLEAVE_MAX) begin
      rv = $random(seed);
      // words 192 and up lie outside both copy ranges
      host_access(1'b0, ram_addr(8'(192 + rv % 64)), '0);
      n++;
    end
    while (!intr[INTR_DMA] && waited < DMA_MAX_LEN * WORD_BOUND) begin
      @(posedge clk);
      waited++;
    end
    if (!intr[INTR_DMA]) begin
      @(posedge clk);
      dma_timeout <= 1'b1;
      @(posedge clk);
      dma_timeout <= 1'b0;
    end
    host_access(1'b0, periph_addr(BLOCK_DMA, DMA_CTRL), '0);
    check_pins();
    for (n = 0; n < len; n++) begin
      host_access(1'b0, dst + 32'(4 * n), '0);
    end
    host_access(1'b1, periph_addr(BLOCK_DMA, DMA_CTRL), 32'(1 << DMA_DONE));
    repeat (2) @(posedge clk);
    check_pins();
  endtask

  initial begin
    seed          = 32'h374b;
    rst           <= 1'b1;
    host_cyc      <= 1'b0;
    host_stb      <= 1'b0;
    host_we       <= 1'b0;
    host_adr      <= '0;
    host_wdat     <= '0;
    pins_in       <= '0;
    test_idx      <= 4'd0;
    check_outputs <= 1'b0;
    host_timeout  <= 1'b0;
    dma_timeout   <= 1'b0;
    all_done      <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // every word is written first, so the model knows all of RAM
    test_idx <= 4'd1;
    for (int i = 0; i < RAM_WORDS; i++) begin
      host_access(1'b1, ram_addr(8'(i)), $random(seed));
    end
    for (int i = 0; i < RAM_READS; i++) begin
      r = $random(seed);
      host_access(1'b0, ram_addr(r[7:0]), '0);
    end

    test_idx <= 4'd2;
    for (int i = 0; i < UNMAPPED_TRIES; i++) begin
      r = $random(seed);
      if (i % 2 == 0) begin
        adr = {4'(2 + r[31:28] % 14), r[27:2], 2'b00};
      end else begin
        adr = {REGION_PERIPH, r[27:12], 4'(2 + r[11:8] % 14), r[7:2], 2'b00};
      end
      host_access(r[0], adr, $random(seed));
      host_access(1'b0, ram_addr(adr[9:2]), '0);
    end

    test_idx <= 4'd3;
    for (int i = 0; i < GPIO_ROUNDS; i++) begin
      host_access(1'b1, periph_addr(BLOCK_GPIO, GPIO_OUT), $random(seed));
      host_access(1'b1, periph_addr(BLOCK_GPIO, GPIO_OE), $random(seed));
      @(posedge clk);
      pins_in <= $random(seed);
      repeat (3) @(posedge clk);
      check_pins();
      host_access(1'b0, periph_addr(BLOCK_GPIO, GPIO_IN), '0);
    end

    // pins settle low before the enables change, then rise together
    test_idx <= 4'd4;
    @(posedge clk);
    pins_in <= '0;
    repeat (4) @(posedge clk);
    r = $random(seed);
    host_access(1'b1, periph_addr(BLOCK_GPIO, GPIO_IRQ_EN), r | 32'h1);
    @(posedge clk);
    r = $random(seed);
    pins_in <= r | 32'h1;
    repeat (5) @(posedge clk);
    check_pins();
    host_access(1'b0, periph_addr(BLOCK_GPIO, GPIO_IRQ_STATUS), '0);
    host_access(1'b1, periph_addr(BLOCK_GPIO, GPIO_IRQ_STATUS), 32'hFFFF_FFFF);
    repeat (3) @(posedge clk);
    check_pins();
    host_access(1'b0, periph_addr(BLOCK_GPIO, GPIO_IRQ_STATUS), '0);

    test_idx <= 4'd5;
    r = $random(seed);
    run_dma(ram_addr(8'(r[7:0] % 48)), ram_addr(8'(128 + r[15:8] % 48)),
            1 + r[23:16] % DMA_MAX_LEN, 1'b1);

    // source lies in an unmapped region
    test_idx <= 4'd6;
    r = $random(seed);
    run_dma(32'h3000_0000 | (r & 32'h0FFF_FFFC), ram_addr(8'(128 + r[15:8] % 48)),
            1 + r[19:16] % 8, 1'b0);

    all_done <= 1'b1;
    while (!finished) begin
      @(posedge clk);
    end
    if (failed) begin
      $display("RESULT: FAIL");
    end else begin
      $display("RESULT: PASS");
    end
    $finish;
  end

endmodule

/* build.f */
logic/mcu_pkg.sv
logic/bus_arbiter.sv
logic/bus_decoder.sv
logic/ram_bank.sv
logic/dma_engine.sv
logic/gpio_block.sv
logic/mini_mcu.sv
tb/mcu_checker.sv
tb/tb_mini_mcu.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module tb_mini_mcu -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
